// File: Makefile
TOP = tb_conv

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f vlog.f --top-module conv_top

sim:
	verilator --binary --timing -Wno-fatal -f vlog.f --top-module $(TOP) \
		--Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q ">>> PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: cla_adder.sv
`timescale 1ns/1ps

module cla_adder #(
  parameter int WIDTH = 20
) (
  input  logic [WIDTH-1:0] a,
  input  logic [WIDTH-1:0] b,
  output logic [WIDTH-1:0] s
);

  localparam int GROUPS = (WIDTH + 3) / 4;
  localparam int PW     = GROUPS * 4;  // width rounded up to whole groups

  logic [PW-1:0]     a_ext;
  logic [PW-1:0]     b_ext;
  logic [PW-1:0]     s_ext;
  logic [PW-1:0]     p;
  logic [PW-1:0]     g;
  logic [GROUPS-1:0] gp;  // group propagate
  logic [GROUPS-1:0] gg;  // group generate
  logic [GROUPS-1:0] gc;  // carry into each group

  assign a_ext = PW'(a);
  assign b_ext = PW'(b);
  assign p     = a_ext ^ b_ext;
  assign g     = a_ext & b_ext;
  assign gc[0] = 1'b0;

  for (genvar k = 0; k < GROUPS; k++) begin : g_grp
    logic [3:0] pk;
    logic [3:0] gk;
    logic [3:0] c;
    assign pk    = p[4*k +: 4];
    assign gk    = g[4*k +: 4];
    assign gp[k] = &pk;
    assign gg[k] = gk[3] | (gk[2] & pk[3]) | (gk[1] & pk[2] & pk[3]) |
                   (gk[0] & pk[1] & pk[2] & pk[3]);
    // bit carries looked ahead from the group carry
    assign c[0] = gc[k];
    assign c[1] = gk[0] | (pk[0] & c[0]);
    assign c[2] = gk[1] | (pk[1] & gk[0]) | (pk[1] & pk[0] & c[0]);
    assign c[3] = gk[2] | (pk[2] & gk[1]) | (pk[2] & pk[1] & gk[0]) |
                  (pk[2] & pk[1] & pk[0] & c[0]);
    assign s_ext[4*k +: 4] = pk ^ c;
    if (k < GROUPS - 1) begin : g_carry
      assign gc[k+1] = gg[k] | (gp[k] & gc[k]);  // group carry generator
    end
  end

  assign s = s_ext[WIDTH-1:0];

endmodule

// File: conv_ctrl_pkg.sv
package conv_ctrl_pkg;

  // sequencing states of the engine
  typedef enum logic [2:0] {
    IDLE      = 3'd0,
    LOAD_FEAT = 3'd1,  // feature words into feat_ram
    LOAD_WGT  = 3'd2,  // weight words into wgt_ram
    COMPUTE   = 3'd3,  // taps issue one per cycle
    WAIT_SEND = 3'd4   // group done, output word pending
  } conv_state_t;

  ////////////////////////////////////////
  // layout of the weight block
  ////////////////////////////////////////
  localparam int WGT_WORDS = 3;  // nine weights and the bias

  // bias is byte 9 of the block, lanes 2 and 3 of word 2 unused
  localparam int BIAS_LANE = 1;

endpackage

// File: conv_data_pkg.sv
package conv_data_pkg;

  // pixel and weight formats
  typedef logic signed [7:0] pixel_t;
  typedef logic signed [7:0] weight_t;

  // lane 0 sits in bits 7..0 and carries the leftmost pixel
  typedef pixel_t  [3:0] feat_quad_t;
  typedef weight_t [3:0] weight_quad_t;

  typedef logic signed [15:0] product_t;  // one tap product
  typedef logic signed [19:0] acc_t;      // nine products plus shifted bias
  typedef logic        [31:0] stream_word_t;

  ////////////////////////////////////////
  // arithmetic constants
  ////////////////////////////////////////
  localparam int LANES       = 4;    // pixels per stream word
  localparam int TAPS        = 9;    // 3x3 kernel
  localparam int QUANT_SHIFT = 6;    // fixed point of the accumulator
  localparam int PIX_MAX     = 127;  // requantized ceiling

endpackage

// File: conv_fsm.sv
`timescale 1ns/1ps

module conv_fsm (
  input  logic clk,
  input  logic rstn,
  input  logic start,
  input  logic in_valid,
  input  logic load_last,
  input  logic group_done,
  input  logic last_group,
  input  logic word_sent,
  output logic in_ready,
  output logic load_beat_feat,
  output logic load_beat_wgt,
  output logic bias_load,
  output logic scan_en,
  output logic done
);
  import conv_ctrl_pkg::*;

  conv_state_t state;

  ////////////////////////////////////////
  // strobes
  ////////////////////////////////////////
  assign load_beat_feat = (state == LOAD_FEAT) && in_valid && in_ready;
  assign load_beat_wgt  = (state == LOAD_WGT) && in_valid && in_ready;
  assign bias_load      = load_beat_wgt && load_last;  // weight word 2 carries the bias
  assign scan_en        = (state == COMPUTE);

  ////////////////////////////////////////
  // state register
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstn) begin
      state    <= IDLE;
      in_ready <= 1'b0;
      done     <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        IDLE: begin
          if (start) begin
            state    <= LOAD_FEAT;
            in_ready <= 1'b1;
          end
        end
        LOAD_FEAT: begin
          if (load_beat_feat && load_last) begin
            state <= LOAD_WGT;  // in_ready stays up
          end
        end
        LOAD_WGT: begin
          if (load_beat_wgt && load_last) begin
            state    <= COMPUTE;
            in_ready <= 1'b0;
          end
        end
        COMPUTE: begin
          if (group_done) begin
            state <= WAIT_SEND;  // hold the scan at the group boundary
          end
        end
        WAIT_SEND: begin
          if (word_sent) begin
            if (last_group) begin
              state <= IDLE;
              done  <= 1'b1;
            end else begin
              state <= COMPUTE;
            end
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

endmodule

// File: conv_top.sv
`timescale 1ns/1ps

module conv_top #(
  parameter int FEAT_LEN = 8
) (
  input  logic                        clk,
  input  logic                        rstn,
  input  logic                        start,
  output logic                        done,
  input  conv_data_pkg::stream_word_t in_data,
  input  logic                        in_valid,
  output logic                        in_ready,
  output conv_data_pkg::stream_word_t out_data,
  output logic                        out_valid,
  input  logic                        out_ready,
  output logic                        out_last
);
  import conv_data_pkg::*;
  import conv_ctrl_pkg::*;

  localparam int FEAT_WORDS = FEAT_LEN * FEAT_LEN / LANES;
  localparam int FA_W       = $clog2(FEAT_WORDS);
  localparam int WA_W       = $clog2(WGT_WORDS);

  logic            load_beat_feat;
  logic            load_beat_wgt;
  logic            bias_load;
  logic            scan_en;
  logic            load_last;
  logic            group_done;
  logic            last_group;
  logic            word_sent;
  logic [FA_W-1:0] feat_addr;
  logic [WA_W-1:0] wgt_addr;
  logic            tap_valid;
  logic            tap_first;
  logic            tap_last;
  logic            pad;
  logic [1:0]      feat_lane;
  logic [1:0]      wgt_lane;
  feat_quad_t      feat_word;
  weight_quad_t    wgt_word;
  logic            acc_valid;
  acc_t            acc;

  conv_fsm u_fsm (
    .clk           (clk),
    .rstn          (rstn),
    .start         (start),
    .in_valid      (in_valid),
    .load_last     (load_last),
    .group_done    (group_done),
    .last_group    (last_group),
    .word_sent     (word_sent),
    .in_ready      (in_ready),
    .load_beat_feat(load_beat_feat),
    .load_beat_wgt (load_beat_wgt),
    .bias_load     (bias_load),
    .scan_en       (scan_en),
    .done          (done)
  );

  window_counter #(
    .FEAT_LEN(FEAT_LEN)
  ) u_win (
    .clk       (clk),
    .rstn      (rstn),
    .load_beat (load_beat_feat | load_beat_wgt),
    .clear     (done),
    .scan_en   (scan_en),
    .feat_addr (feat_addr),
    .wgt_addr  (wgt_addr),
    .load_last (load_last),
    .tap_valid (tap_valid),
    .tap_first (tap_first),
    .tap_last  (tap_last),
    .pad       (pad),
    .feat_lane (feat_lane),
    .wgt_lane  (wgt_lane),
    .group_done(group_done),
    .last_group(last_group)
  );

  ////////////////////////////////////////
  // feature and weight memories
  ////////////////////////////////////////
  word_ram #(
    .DEPTH (FEAT_WORDS),
    .word_t(feat_quad_t)
  ) feat_ram (
    .clk  (clk),
    .en   (1'b1),
    .we   (load_beat_feat),
    .addr (feat_addr),
    .wdata(in_data),
    .rdata(feat_word)
  );

  word_ram #(
    .DEPTH (WGT_WORDS),
    .word_t(weight_quad_t)
  ) wgt_ram (
    .clk  (clk),
    .en   (1'b1),
    .we   (load_beat_wgt),
    .addr (wgt_addr),
    .wdata(in_data),
    .rdata(wgt_word)
  );

  mac_pipe u_mac (
    .clk      (clk),
    .rstn     (rstn),
    .tap_valid(tap_valid),
    .tap_first(tap_first),
    .tap_last (tap_last),
    .pad      (pad),
    .feat_lane(feat_lane),
    .wgt_lane (wgt_lane),
    .feat_word(feat_word),
    .wgt_word (wgt_word),
    .acc_valid(acc_valid),
    .acc      (acc)
  );

  requant_pack u_rq (
    .clk       (clk),
    .rstn      (rstn),
    .bias_load (bias_load),
    .in_data   (in_data),
    .acc_valid (acc_valid),
    .acc       (acc),
    .group_last(last_group),
    .out_ready (out_ready),
    .out_data  (out_data),
    .out_valid (out_valid),
    .out_last  (out_last),
    .word_sent (word_sent)
  );

endmodule

// File: mac_pipe.sv
`timescale 1ns/1ps

module mac_pipe (
  input  logic                        clk,
  input  logic                        rstn,
  input  logic                        tap_valid,
  input  logic                        tap_first,
  input  logic                        tap_last,
  input  logic                        pad,
  input  logic [1:0]                  feat_lane,
  input  logic [1:0]                  wgt_lane,
  input  conv_data_pkg::feat_quad_t   feat_word,
  input  conv_data_pkg::weight_quad_t wgt_word,
  output logic                        acc_valid,
  output conv_data_pkg::acc_t         acc
);
  import conv_data_pkg::*;

  logic [4:0]  v_sr;     // bit 0 lines up with the memory data
  logic [4:0]  f_sr;
  logic [4:0]  l_sr;
  logic [2:0]  sgn_sr;   // product sign, follows the multiplier data
  logic        pad_a;
  logic [1:0]  flane_a;
  logic [1:0]  wlane_a;
  pixel_t      pix;
  weight_t     wgt;
  logic [7:0]  pix_mag;
  logic [7:0]  wgt_mag;
  logic [7:0]  pp [8];   // partial products, shift implied by index
  logic [9:0]  pair [4];
  logic [15:0] mag;
  product_t    prod;
  acc_t        acc_prev;
  acc_t        acc_sum;

  ////////////////////////////////////////
  // tap flags and memory alignment
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstn) begin
      v_sr <= '0;
    end else begin
      v_sr <= {v_sr[3:0], tap_valid};
    end
  end

  always_ff @(posedge clk) begin
    f_sr    <= {f_sr[3:0], tap_first};
    l_sr    <= {l_sr[3:0], tap_last};
    pad_a   <= pad;
    flane_a <= feat_lane;
    wlane_a <= wgt_lane;
  end

  assign pix     = pad_a ? pixel_t'(0) : feat_word[flane_a];  // zero padding
  assign wgt     = wgt_word[wlane_a];
  assign pix_mag = pix[7] ? 8'(-pix) : 8'(pix);
  assign wgt_mag = wgt[7] ? 8'(-wgt) : 8'(wgt);

  ////////////////////////////////////////
  // sign-magnitude multiplier, 4 stages
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    for (int i = 0; i < 8; i++) begin
      pp[i] <= wgt_mag[i] ? pix_mag : 8'd0;
    end
    for (int k = 0; k < 4; k++) begin
      pair[k] <= {2'b00, pp[2*k]} + {1'b0, pp[2*k+1], 1'b0};  // tree level 1
    end
    mag <= 16'(pair[0]) + (16'(pair[1]) << 2) + (16'(pair[2]) << 4) +
           (16'(pair[3]) << 6);  // tree level 2
    prod   <= sgn_sr[2] ? product_t'(-mag) : product_t'(mag);
    sgn_sr <= {sgn_sr[1:0], pix[7] ^ wgt[7]};
  end

  ////////////////////////////////////////
  // accumulate
  ////////////////////////////////////////
  assign acc_prev = f_sr[4] ? acc_t'(0) : acc;  // first tap restarts the sum

  cla_adder #(
    .WIDTH($bits(acc_t))
  ) u_acc_add (
    .a(acc_t'(prod)),
    .b(acc_prev),
    .s(acc_sum)
  );

  always_ff @(posedge clk) begin
    if (v_sr[4]) begin
      acc <= acc_sum;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      acc_valid <= 1'b0;
    end else begin
      acc_valid <= v_sr[4] && l_sr[4];  // pixel complete
    end
  end

endmodule

// File: requant_pack.sv
`timescale 1ns/1ps

module requant_pack (
  input  logic                        clk,
  input  logic                        rstn,
  input  logic                        bias_load,
  input  conv_data_pkg::stream_word_t in_data,
  input  logic                        acc_valid,
  input  conv_data_pkg::acc_t         acc,
  input  logic                        group_last,
  input  logic                        out_ready,
  output conv_data_pkg::stream_word_t out_data,
  output logic                        out_valid,
  output logic                        out_last,
  output logic                        word_sent
);
  import conv_data_pkg::*;
  import conv_ctrl_pkg::*;

  weight_t    bias;
  acc_t       bias_term;
  acc_t       sum;
  pixel_t     pix;
  logic [1:0] lane;      // next lane to fill
  feat_quad_t out_word;

  always_ff @(posedge clk) begin
    if (bias_load) begin
      bias <= in_data[BIAS_LANE*8 +: 8];
    end
  end

  assign bias_term = acc_t'(bias) <<< QUANT_SHIFT;  // same scale as the products

  cla_adder #(
    .WIDTH($bits(acc_t))
  ) u_bias_add (
    .a(acc),
    .b(bias_term),
    .s(sum)
  );

  // negative to 0, saturate at PIX_MAX
  always_comb begin
    if (sum < 0) begin
      pix = pixel_t'(0);
    end else if ((sum >>> QUANT_SHIFT) > PIX_MAX) begin
      pix = pixel_t'(PIX_MAX);
    end else begin
      pix = pixel_t'(sum >>> QUANT_SHIFT);
    end
  end

  ////////////////////////////////////////
  // packing and output handshake
  ////////////////////////////////////////
  assign word_sent = out_valid && out_ready;
  assign out_data  = out_word;

  always_ff @(posedge clk) begin
    if (acc_valid) begin
      out_word[lane] <= pix;  // no writes while a word is pending
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      lane      <= 2'd0;
      out_valid <= 1'b0;
      out_last  <= 1'b0;
    end else begin
      if (word_sent) begin
        out_valid <= 1'b0;
        out_last  <= 1'b0;
      end
      if (acc_valid) begin
        lane <= lane + 1'b1;
        if (lane == 2'd3) begin
          out_valid <= 1'b1;
          out_last  <= group_last;
        end
      end
    end
  end

endmodule

// File: tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter realtime HALF_PERIOD = 2.0,  // 4 ns clock
  parameter int      RST_CYCLES  = 5
) (
  output logic clk,
  output logic rstn
);

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  // reset held low for RST_CYCLES rising edges, released just after an edge
  initial begin
    rstn = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    #1 rstn = 1'b1;
  end

endmodule

// File: tb_conv.sv
`timescale 1ns/1ps

module tb_conv;
  import conv_data_pkg::*;
  import conv_ctrl_pkg::*;

  localparam int FEAT_LEN   = 8;
  localparam int FEAT_WORDS = FEAT_LEN * FEAT_LEN / LANES;
  localparam int N_IN       = FEAT_WORDS + WGT_WORDS;
  localparam int N_OUT      = FEAT_WORDS;  // one output pixel per input pixel
  localparam int GAP_LEN    = 4096;

  logic         clk;
  logic         rstn;
  logic         start;
  logic         done;
  stream_word_t in_data;
  logic         in_valid;
  logic         in_ready;
  stream_word_t out_data;
  logic         out_valid;
  logic         out_ready;
  logic         out_last;

  pixel_t       feat_pix [FEAT_LEN*FEAT_LEN];
  weight_t      kern [TAPS];
  weight_t      bias_val;
  stream_word_t in_words [N_IN];
  stream_word_t exp_words [N_OUT];
  bit           in_gap [GAP_LEN];     // valid gaps and ready stalls, one entry per cycle
  bit           out_stall [GAP_LEN];
  int           in_step;
  int           out_step;

  tb_clk_gen u_clk (
    .clk (clk),
    .rstn(rstn)
  );

  conv_top #(
    .FEAT_LEN(FEAT_LEN)
  ) uut (
    .clk      (clk),
    .rstn     (rstn),
    .start    (start),
    .done     (done),
    .in_data  (in_data),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .out_data (out_data),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .out_last (out_last)
  );

  ////////////////////////////////////////
  // failure reporting and compares
  ////////////////////////////////////////
  task automatic fail_now(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(input string name, input stream_word_t got, input stream_word_t exp);
    if (got !== exp) begin
      fail_now($sformatf("** Error %s: got 0x%08h expected 0x%08h", name, got, exp));
    end
  endtask

  task automatic check_last(input logic got, input logic exp);
    if (got !== exp) begin
      fail_now($sformatf("** Error out_last: got 0x%0h expected 0x%0h", got, exp));
    end
  endtask

  task automatic check_done(input logic got, input logic exp);
    if (got !== exp) begin
      fail_now($sformatf("** Error done: got 0x%0h expected 0x%0h", got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_now($sformatf("** Error %s: got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  ////////////////////////////////////////
  // stimulus and reference model
  ////////////////////////////////////////
  // mode 0 random, 1 large positive weights, 2 large negative weights
  task automatic make_stimulus(input int mode);
    for (int i = 0; i < FEAT_LEN * FEAT_LEN; i++) begin
      if (mode == 0) begin
        feat_pix[i] = pixel_t'($urandom);
      end else begin
        feat_pix[i] = pixel_t'(64 + $urandom % 64);
      end
    end
    for (int t = 0; t < TAPS; t++) begin
      case (mode)
        0:       kern[t] = weight_t'($urandom);
        1:       kern[t] = weight_t'(100 + $urandom % 28);
        default: kern[t] = weight_t'(-100 - int'($urandom % 28));
      endcase
    end
    bias_val = weight_t'($urandom);
  endtask

  // padded 3x3 sum at (r, c), plus bias, then requantized
  function automatic int ref_pixel(input int r, input int c);
    int s;
    int y;
    int x;
    s = 0;
    for (int tr = 0; tr < 3; tr++) begin
      for (int tc = 0; tc < 3; tc++) begin
        y = r + tr - 1;
        x = c + tc - 1;
        if (y >= 0 && y < FEAT_LEN && x >= 0 && x < FEAT_LEN) begin
          s += int'(feat_pix[y*FEAT_LEN + x]) * int'(kern[tr*3 + tc]);
        end
      end
    end
    s += int'(bias_val) * 64;
    if (s < 0) begin
      return 0;
    end
    if ((s / 64) > 127) begin
      return 127;
    end
    return s / 64;
  endfunction

  task automatic build_model();
    stream_word_t w;
    for (int i = 0; i < FEAT_WORDS; i++) begin
      for (int l = 0; l < LANES; l++) begin
        w[8*l +: 8] = feat_pix[i*LANES + l];  // lane 0 leftmost
      end
      in_words[i] = w;
    end
    for (int k = 0; k < WGT_WORDS; k++) begin
      w = stream_word_t'($urandom);  // lanes past tap 8 keep junk
      for (int l = 0; l < LANES; l++) begin
        if (4*k + l < TAPS) begin
          w[8*l +: 8] = kern[4*k + l];
        end
      end
      in_words[FEAT_WORDS + k] = w;
    end
    in_words[FEAT_WORDS + 2][8*BIAS_LANE +: 8] = bias_val;  // byte 9
    for (int r = 0; r < FEAT_LEN; r++) begin
      for (int cw = 0; cw < FEAT_LEN / LANES; cw++) begin
        for (int l = 0; l < LANES; l++) begin
          w[8*l +: 8] = 8'(ref_pixel(r, cw*LANES + l));
        end
        exp_words[r*(FEAT_LEN/LANES) + cw] = w;
      end
    end
  endtask

  ////////////////////////////////////////
  // stream drivers
  ////////////////////////////////////////
  // all loops enter and leave 1 ns after a rising edge
  task automatic send_stream(input bit gaps);
    int idx;
    int wait_cnt;
    idx      = 0;
    wait_cnt = 0;
    while (idx < N_IN) begin
      in_valid = !(gaps && in_gap[in_step % GAP_LEN]);
      in_data  = in_words[idx];
      in_step++;
      @(negedge clk);
      if (in_valid && in_ready) begin
        idx++;
        wait_cnt = 0;
      end else begin
        wait_cnt++;
        if (wait_cnt > 50) begin
          fail_now("timeout: input word was not accepted");
        end
      end
      @(posedge clk);
      #1;
    end
    in_valid = 1'b0;
    in_data  = '0;
  endtask

  task automatic collect_words(input bit stalls);
    int           n;
    int           wait_cnt;
    logic         pend;
    stream_word_t pdata;
    logic         plast;
    n        = 0;
    wait_cnt = 0;
    pend     = 1'b0;
    while (n < N_OUT) begin
      out_ready = !(stalls && out_stall[out_step % GAP_LEN]);
      out_step++;
      @(negedge clk);
      check_done(done, 1'b0);
      if (pend) begin  // stalled word must hold
        check_flag("out_valid", out_valid, 1'b1);
        check_word("out_data", out_data, pdata);
        check_last(out_last, plast);
      end
      if (out_valid && out_ready) begin
        check_word("out_data", out_data, exp_words[n]);
        check_last(out_last, n == N_OUT - 1);
        n++;
        wait_cnt = 0;
      end else begin
        wait_cnt++;
        if (wait_cnt > 300) begin
          fail_now("timeout: no output word arrived");
        end
      end
      pend  = out_valid && !out_ready;
      pdata = out_data;
      plast = out_last;
      @(posedge clk);
      #1;
    end
    out_ready = 1'b0;
    @(negedge clk);
    check_done(done, 1'b1);  // one cycle after the final word
    @(posedge clk);
    #1;
    @(negedge clk);
    check_done(done, 1'b0);
    check_flag("in_ready", in_ready, 1'b0);
    @(posedge clk);
    #1;
  endtask

  task automatic run_conv(input int mode, input bit gaps);
    make_stimulus(mode);
    build_model();
    start = 1'b1;
    @(negedge clk);
    check_flag("in_ready", in_ready, 1'b0);
    @(posedge clk);
    #1;
    start = 1'b0;
    @(negedge clk);
    check_flag("in_ready", in_ready, 1'b1);
    @(posedge clk);
    #1;
    fork
      send_stream(gaps);
      collect_words(gaps);
    join
  endtask

  initial begin
    int cnt;
    start     = 1'b0;
    in_data   = '0;
    in_valid  = 1'b0;
    out_ready = 1'b0;
    in_step   = 0;
    out_step  = 0;
    cnt       = 0;
    void'($urandom(35));
    for (int i = 0; i < GAP_LEN; i++) begin
      in_gap[i]    = ($urandom % 4) == 0;
      out_stall[i] = ($urandom % 3) == 0;
    end
    while (!rstn) begin
      @(posedge clk);
      #1;
      cnt++;
      if (cnt > 20) begin
        fail_now("timeout: reset was never released");
      end
    end
    @(negedge clk);
    check_flag("in_ready", in_ready, 1'b0);
    check_flag("out_valid", out_valid, 1'b0);
    check_last(out_last, 1'b0);
    check_done(done, 1'b0);
    @(posedge clk);
    #1;
    run_conv(0, 1'b0);  // clean streams
    run_conv(0, 1'b1);  // input gaps and output stalls
    run_conv(1, 1'b1);  // every pixel saturates at 127
    run_conv(2, 1'b1);  // every pixel clamps to 0
    $display(">>> PASS");
    $finish;
  end

endmodule

// File: vlog.f
conv_data_pkg.sv
conv_ctrl_pkg.sv
cla_adder.sv
word_ram.sv
window_counter.sv
conv_fsm.sv
mac_pipe.sv
requant_pack.sv
conv_top.sv
tb_clk_gen.sv
tb_conv.sv

// File: window_counter.sv
`timescale 1ns/1ps

module window_counter #(
  parameter int  FEAT_LEN = 8,
  localparam int FA_W     = $clog2(FEAT_LEN * FEAT_LEN / conv_data_pkg::LANES),
  localparam int WA_W     = $clog2(conv_ctrl_pkg::WGT_WORDS)
) (
  input  logic            clk,
  input  logic            rstn,
  input  logic            load_beat,
  input  logic            clear,
  input  logic            scan_en,
  output logic [FA_W-1:0] feat_addr,
  output logic [WA_W-1:0] wgt_addr,
  output logic            load_last,
  output logic            tap_valid,
  output logic            tap_first,
  output logic            tap_last,
  output logic            pad,
  output logic [1:0]      feat_lane,
  output logic [1:0]      wgt_lane,
  output logic            group_done,
  output logic            last_group
);
  import conv_data_pkg::*;
  import conv_ctrl_pkg::*;

  localparam int FEAT_WORDS = FEAT_LEN * FEAT_LEN / LANES;
  localparam int WPR        = FEAT_LEN / LANES;  // words per row
  localparam int RW         = $clog2(FEAT_LEN);

  logic [FA_W-1:0] load_cnt;
  logic            wgt_phase;  // feature block done, counting weights
  logic [1:0]      tr;         // tap row in the window
  logic [1:0]      tc;         // tap column
  logic [RW-1:0]   row;
  logic [RW-1:0]   col;
  logic [3:0]      tap_idx;
  logic [FA_W-1:0] scan_addr;
  logic            at_end;

  ////////////////////////////////////////
  // load addressing
  ////////////////////////////////////////
  assign load_last = wgt_phase ? (load_cnt == FA_W'(WGT_WORDS - 1))
                               : (load_cnt == FA_W'(FEAT_WORDS - 1));

  always_ff @(posedge clk) begin
    if (!rstn || clear) begin
      load_cnt  <= '0;
      wgt_phase <= 1'b0;
    end else if (load_beat) begin
      if (load_last) begin
        load_cnt  <= '0;
        wgt_phase <= ~wgt_phase;
      end else begin
        load_cnt <= load_cnt + 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // tap, column, row scan
  ////////////////////////////////////////
  assign tap_idx    = 4'(tr * 3) + 4'(tc);
  assign tap_valid  = scan_en;
  assign tap_first  = (tap_idx == 4'd0);
  assign tap_last   = (tap_idx == 4'(TAPS - 1));
  assign group_done = scan_en && tap_last && (col[1:0] == 2'b11);
  assign at_end     = (row == RW'(FEAT_LEN - 1)) && (col == RW'(FEAT_LEN - 1));

  always_ff @(posedge clk) begin
    if (!rstn || clear) begin
      tr         <= 2'd0;
      tc         <= 2'd0;
      row        <= '0;
      col        <= '0;
      last_group <= 1'b0;
    end else if (scan_en) begin
      if (group_done) begin
        last_group <= at_end;  // holds until the next group ends
      end
      if (tc == 2'd2) begin
        tc <= 2'd0;
        if (tr == 2'd2) begin
          tr <= 2'd0;
          if (col == RW'(FEAT_LEN - 1)) begin
            col <= '0;
            row <= (row == RW'(FEAT_LEN - 1)) ? '0 : row + 1'b1;
          end else begin
            col <= col + 1'b1;
          end
        end else begin
          tr <= tr + 1'b1;
        end
      end else begin
        tc <= tc + 1'b1;
      end
    end
  end

  // window position relative to the output pixel, border taps padded
  always_comb begin
    int y;
    int x;
    y = int'(row) + int'(tr) - 1;
    x = int'(col) + int'(tc) - 1;
    pad       = (y < 0) || (y >= FEAT_LEN) || (x < 0) || (x >= FEAT_LEN);
    scan_addr = '0;
    feat_lane = 2'd0;
    if (!pad) begin
      scan_addr = FA_W'(y * WPR + x / LANES);
      feat_lane = 2'(x % LANES);
    end
  end

  assign feat_addr = scan_en ? scan_addr : load_cnt;
  assign wgt_addr  = scan_en ? WA_W'(tap_idx / LANES) : load_cnt[WA_W-1:0];
  assign wgt_lane  = tap_idx[1:0];

endmodule

// File: word_ram.sv
`timescale 1ns/1ps

module word_ram #(
  parameter int  DEPTH  = 16,
  parameter type word_t = logic [31:0]
) (
  input  logic                     clk,
  input  logic                     en,
  input  logic                     we,
  input  logic [$clog2(DEPTH)-1:0] addr,
  input  word_t                    wdata,
  output word_t                    rdata
);

  word_t mem [DEPTH];

  // one port, read data registered
  always_ff @(posedge clk) begin
    if (en) begin
      if (we) begin
        mem[addr] <= wdata;
      end
      rdata <= mem[addr];  // old contents on a write cycle
    end
  end

endmodule
